// File: hw/dram_consts.svh
`ifndef DRAM_CONSTS_SVH
`define DRAM_CONSTS_SVH

// Refresh timing, in CLK cycles
`define REF_PERIOD 64   // Interval between refresh requests
`define REF_URGENT 16   // Grace before a pending request turns urgent

// DRAM multiplexed address width
`define ROW_BITS 12

// Region codes, taken from A21:A20
`define REG_RAM_LOW 2'b00   // Low RAM, refresh must wait for it
`define REG_RAM     2'b01   // Upper RAM, A21:A20 = 01 or 10
`define REG_ROM     2'b11   // NOR flash ROM

`endif

// File: hw/memPkg.sv
`include "dram_consts.svh"

package memPkg;

	// DRAM controller states, refresh states sit in the upper half
	typedef enum logic [3:0] {
		stIdle     = 4'd0,    // Ready for an access
		stAccess   = 4'd1,    // Row strobed
		stHold     = 4'd2,    // Column strobed, waiting for /DTACK
		stEnd      = 4'd3,    // Cycle complete
		stRefCas   = 4'd8,    // CAS ahead of RAS
		stRefRas1  = 4'd9,
		stRefRas2  = 4'd10,
		stPre1     = 4'd11,   // RAS precharge
		stPre2     = 4'd12,
		stReenable = 4'd15    // Back to ready
	} dramState_e;

	// Address regions
	typedef enum logic [1:0] {
		regRamLow = `REG_RAM_LOW,
		regRam    = `REG_RAM,
		regRom    = `REG_ROM
	} region_e;

endpackage

// File: hw/cpuBusIf.sv
interface cpuBusIf import memPkg::*; ();

	logic [21:1] A;
	logic nWE;
	logic nAS;
	logic nLDS;
	logic nUDS;
	logic bact;       // Bus cycle active, /AS sampled
	logic bactR;      // bact one cycle later
	logic dtackR;     // Registered /DTACK, high true
	region_e region;  // Decoded from A21:A20

	modport dec (
		output A,
		output nWE,
		output nAS,
		output nLDS,
		output nUDS,
		output bact,
		output bactR,
		output dtackR,
		output region
	);

	modport ctrl (
		input bact,
		input bactR,
		input dtackR,
		input region
	);

	modport pins (
		input A,
		input nWE,
		input nAS,
		input nLDS,
		input nUDS,
		input bact,
		input bactR,
		input dtackR,
		input region
	);

endinterface

// File: hw/busDecode.sv
module busDecode import memPkg::*; (
	input  logic        CLK,
	input  logic        rstN,
	input  logic [21:1] A,
	input  logic        nWE,
	input  logic        nAS,
	input  logic        nLDS,
	input  logic        nUDS,
	input  logic        nDTACK,
	cpuBusIf.dec        bus
);

	// Raw CPU signals go to the pin driver unchanged
	assign bus.A    = A;
	assign bus.nWE  = nWE;
	assign bus.nAS  = nAS;
	assign bus.nLDS = nLDS;
	assign bus.nUDS = nUDS;

	// Region decode from the top two address bits
	always_comb begin
		case (A[21:20])
			2'b00:   bus.region = regRamLow;
			2'b11:   bus.region = regRom;
			default: bus.region = regRam;   // 01 and 10
		endcase
	end

	// bact follows /AS one edge late, bactR one more
	// A cycle start is the single cycle with bact high and bactR low
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			bus.bact  <= 1'b0;
			bus.bactR <= 1'b0;
		end else begin
			bus.bact  <= !nAS;
			bus.bactR <= bus.bact;
		end
	end

	// /DTACK comes from the system glue, sampled once per edge
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			bus.dtackR <= 1'b0;
		end else begin
			bus.dtackR <= !nDTACK;   // High true inside the design
		end
	end

endmodule

// File: hw/refreshTimer.sv
`include "dram_consts.svh"

module refreshTimer (
	input  logic CLK,
	input  logic rstN,
	input  logic refAck,
	output logic refReq,
	output logic refUrg
);

	localparam int PeriodW = $clog2(`REF_PERIOD + 1);
	localparam int UrgW    = $clog2(`REF_URGENT + 1);

	logic [PeriodW-1:0] periodCnt;
	logic [UrgW-1:0]    urgCnt;
	logic               periodDone;
	logic               urgDone;

	assign periodDone = periodCnt == PeriodW'(`REF_PERIOD - 1);
	assign urgDone    = urgCnt == UrgW'(`REF_URGENT - 1);

	// Interval counter, restarted by each acknowledge
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			periodCnt <= '0;
			refReq    <= 1'b0;
		end else if (refAck) begin
			periodCnt <= '0;
			refReq    <= 1'b0;
		end else begin
			periodCnt <= periodDone ? '0 : periodCnt + 1'b1;
			if (periodDone)
				refReq <= 1'b1;   // Stays up until served
		end
	end

	// Escalation counter, runs only while a request waits
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			urgCnt <= '0;
			refUrg <= 1'b0;
		end else if (refAck) begin
			urgCnt <= '0;
			refUrg <= 1'b0;
		end else if (refReq && !refUrg) begin
			if (urgDone)
				refUrg <= 1'b1;
			else
				urgCnt <= urgCnt + 1'b1;
		end
	end

endmodule

// File: hw/dramCtrl.sv
module dramCtrl import memPkg::*; (
	input  logic  CLK,
	input  logic  rstN,
	cpuBusIf.ctrl bus,
	input  logic  refReq,
	input  logic  refUrg,
	output logic  refAck,     // One cycle on entry to stPre1
	output logic  rasSel,     // Column phase of the address mux
	output logic  rasRow,     // Row strobe held by the FSM
	output logic  rasEn,      // Lets /AS drive RAS directly
	output logic  rasTrail,   // Row strobe extended to the falling edge
	output logic  ramReady,
	output logic  nCAS
);

	dramState_e state;
	logic       ramSel;
	logic       lowFree;
	logic       cycleStart;
	logic       goRefresh;

	assign ramSel     = bus.region != regRom;
	assign lowFree    = bus.region != regRamLow;   // Foreign cycle, low RAM untouched
	assign cycleStart = bus.bact && !bus.bactR;

	// Normal requests slip in at the start of a foreign cycle,
	// urgent ones whenever low RAM is not being used
	assign goRefresh = (refReq && cycleStart && lowFree) ||
		(refUrg && bus.bact && lowFree) ||
		(refUrg && !bus.bact);

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			state    <= stIdle;
			rasSel   <= 1'b0;
			rasRow   <= 1'b0;
			rasEn    <= 1'b0;
			ramReady <= 1'b1;
			refAck   <= 1'b0;
		end else begin
			// Most states drop these, the case below raises what it needs
			rasSel   <= 1'b0;
			rasRow   <= 1'b0;
			rasEn    <= 1'b0;
			ramReady <= 1'b0;
			refAck   <= 1'b0;
			case (state)
				stIdle: begin
					if (goRefresh) begin
						state <= stRefCas;
					end else if (bus.bact && ramSel && rasEn) begin
						state    <= stAccess;
						rasSel   <= 1'b1;
						rasRow   <= 1'b1;
						rasEn    <= 1'b1;
						ramReady <= 1'b1;
					end else begin
						rasEn    <= 1'b1;   // Stay ready
						ramReady <= 1'b1;
					end
				end
				stAccess: begin
					state    <= stHold;
					rasSel   <= 1'b1;
					ramReady <= 1'b1;
				end
				stHold: begin
					ramReady <= 1'b1;
					if (bus.dtackR)
						state <= stEnd;
					else
						rasSel <= 1'b1;   // Keep column on the pins
				end
				stEnd: begin
					if (refUrg) begin
						state <= stRefCas;
					end else begin
						state    <= stIdle;
						rasEn    <= 1'b1;
						ramReady <= 1'b1;
					end
				end
				stRefCas: begin
					state  <= stRefRas1;
					rasRow <= 1'b1;
				end
				stRefRas1: begin
					state  <= stRefRas2;
					rasRow <= 1'b1;
				end
				stRefRas2: begin
					state  <= stPre1;
					refAck <= 1'b1;
				end
				stPre1: state <= stPre2;
				stPre2: state <= stReenable;
				stReenable: begin
					state    <= stIdle;
					rasEn    <= 1'b1;
					ramReady <= 1'b1;
				end
				default: begin
					state    <= stIdle;
					rasEn    <= 1'b1;
					ramReady <= 1'b1;
				end
			endcase
		end
	end

	// CAS runs half a cycle behind the state, which puts it
	// between the RAS edges for both access and CBR refresh
	always_ff @(negedge CLK or negedge rstN) begin
		if (!rstN) begin
			nCAS     <= 1'b1;
			rasTrail <= 1'b0;
		end else begin
			rasTrail <= state == stAccess;
			case (state)
				stAccess:  nCAS <= 1'b0;
				stHold:    nCAS <= bus.dtackR;   // Rises once /DTACK is in
				stRefCas:  nCAS <= 1'b0;
				stRefRas1: nCAS <= 1'b0;
				stRefRas2: nCAS <= 1'b0;
				default:   nCAS <= 1'b1;
			endcase
		end
	end

endmodule

// File: hw/dramPins.sv
`include "dram_consts.svh"

module dramPins import memPkg::*; (
	input  logic                 CLK,
	input  logic                 rstN,
	cpuBusIf.pins                bus,
	input  logic                 rasSel,
	input  logic                 rasRow,
	input  logic                 rasEn,
	input  logic                 rasTrail,
	output logic [`ROW_BITS-1:0] RA,
	output logic                 nRAS,
	output logic                 nLWE,
	output logic                 nUWE,
	output logic                 nOE,
	output logic                 nROMCS,
	output logic                 nROMWE
);

	logic [`ROW_BITS-1:0] rowAddr;
	logic [`ROW_BITS-1:0] colAddr;
	logic                 ramSel;
	logic                 romSel;
	logic                 asLow;

	assign ramSel = bus.region != regRom;
	assign romSel = bus.region == regRom;
	assign asLow  = !bus.nAS;

	// Row and column bit order follows the board wiring.
	// RA3 and RA11 carry the same bits, RA8 and RA11 double as ROM A18/A19
	assign rowAddr = {bus.A[19], bus.A[17], bus.A[15], bus.A[18], bus.A[14:11],
		bus.A[19], bus.A[16], bus.A[10], bus.A[9]};
	assign colAddr = {bus.A[20], bus.A[7], bus.A[8], bus.A[21], bus.A[6:3],
		bus.A[20], bus.A[7], bus.A[2], bus.A[1]};
	assign RA = rasSel ? colAddr : rowAddr;

	// RAS from /AS while enabled, then held by the controller
	assign nRAS = !((asLow && ramSel && rasEn) || rasRow || rasTrail);

	// Byte lanes write only in the column phase
	assign nLWE = !(!bus.nLDS && !bus.nWE && rasSel);
	assign nUWE = !(!bus.nUDS && !bus.nWE && rasSel);

	// ROM strobes
	assign nROMCS = !(romSel && asLow);
	assign nROMWE = !(romSel && asLow && !bus.nWE);

	// Shared output enable for reads, drops once /DTACK was seen
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			nOE <= 1'b1;
		else
			nOE <= !(bus.bact && bus.nWE && !(bus.bactR && bus.dtackR));
	end

endmodule

// File: hw/memTop.sv
`include "dram_consts.svh"

module memTop (
	input  logic                 CLK,
	input  logic                 rstN,
	input  logic [21:1]          A,
	input  logic                 nWE,
	input  logic                 nAS,
	input  logic                 nLDS,
	input  logic                 nUDS,
	input  logic                 nDTACK,
	output logic [`ROW_BITS-1:0] RA,
	output logic                 nRAS,
	output logic                 nCAS,
	output logic                 nLWE,
	output logic                 nUWE,
	output logic                 nOE,
	output logic                 nROMCS,
	output logic                 nROMWE,
	output logic                 ramReady
);

	cpuBusIf bus ();

	logic refReq;
	logic refUrg;
	logic refAck;
	logic rasSel;
	logic rasRow;
	logic rasEn;
	logic rasTrail;

	busDecode uDecode (
		.CLK    (CLK),
		.rstN   (rstN),
		.A      (A),
		.nWE    (nWE),
		.nAS    (nAS),
		.nLDS   (nLDS),
		.nUDS   (nUDS),
		.nDTACK (nDTACK),
		.bus    (bus.dec)
	);

	refreshTimer uRefresh (
		.CLK    (CLK),
		.rstN   (rstN),
		.refAck (refAck),
		.refReq (refReq),
		.refUrg (refUrg)
	);

	dramCtrl uCtrl (
		.CLK      (CLK),
		.rstN     (rstN),
		.bus      (bus.ctrl),
		.refReq   (refReq),
		.refUrg   (refUrg),
		.refAck   (refAck),
		.rasSel   (rasSel),
		.rasRow   (rasRow),
		.rasEn    (rasEn),
		.rasTrail (rasTrail),
		.ramReady (ramReady),
		.nCAS     (nCAS)
	);

	dramPins uPins (
		.CLK      (CLK),
		.rstN     (rstN),
		.bus      (bus.pins),
		.rasSel   (rasSel),
		.rasRow   (rasRow),
		.rasEn    (rasEn),
		.rasTrail (rasTrail),
		.RA       (RA),
		.nRAS     (nRAS),
		.nLWE     (nLWE),
		.nUWE     (nUWE),
		.nOE      (nOE),
		.nROMCS   (nROMCS),
		.nROMWE   (nROMWE)
	);

endmodule

// File: sim/memTb.sv
`include "dram_consts.svh"

module memTb import memPkg::*; ();

	localparam int NumEntries = 8;
	localparam int MaxDly     = 4;
	// One extra entry for the access after the refresh test
	localparam int CycleLimit = (NumEntries + 1) * (MaxDly + 12) + 4 * `REF_PERIOD;

	typedef struct packed {
		logic [21:1] addr;
		logic        write;
		logic [1:0]  lanes;    // Bit 1 upper, bit 0 lower, high = lane used
		logic [2:0]  dly;      // Cycles before /DTACK
		region_e     expReg;
	} entry_t;

	logic                 CLK = 1'b0;
	logic                 rstN;
	logic [21:1]          A;
	logic                 nWE;
	logic                 nAS;
	logic                 nLDS;
	logic                 nUDS;
	logic                 nDTACK;
	logic [`ROW_BITS-1:0] RA;
	logic                 nRAS;
	logic                 nCAS;
	logic                 nLWE;
	logic                 nUWE;
	logic                 nOE;
	logic                 nROMCS;
	logic                 nROMWE;
	logic                 ramReady;

	int          errors   = 0;
	int          checks   = 0;
	int          cycleCnt = 0;
	int unsigned gap;

	entry_t stim [NumEntries] = '{
		'{{2'b00, 19'h12345}, 1'b0, 2'b11, 3'd0, regRamLow},
		'{{2'b01, 19'h5a5a5}, 1'b1, 2'b01, 3'd2, regRam},
		'{{2'b10, 19'h3c3c3}, 1'b1, 2'b10, 3'd1, regRam},
		'{{2'b11, 19'h7ffff}, 1'b0, 2'b11, 3'd1, regRom},
		'{{2'b00, 19'h00fff}, 1'b1, 2'b11, 3'd3, regRamLow},
		'{{2'b11, 19'h40001}, 1'b1, 2'b01, 3'd0, regRom},
		'{{2'b01, 19'h2aaaa}, 1'b0, 2'b11, 3'd4, regRam},
		'{{2'b10, 19'h55555}, 1'b0, 2'b10, 3'd2, regRam}
	};

	memTop uut (.*);

	always #2 CLK = ~CLK;

	always @(posedge CLK) begin
		cycleCnt++;
		if (cycleCnt > CycleLimit) begin
			$display("Timeout: the DUT did not finish within %0d cycles", CycleLimit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// Board wiring of the DRAM address mux
	function automatic logic [11:0] rowOf(input logic [21:1] a);
		return {a[19], a[17], a[15], a[18], a[14:11], a[19], a[16], a[10], a[9]};
	endfunction

	function automatic logic [11:0] colOf(input logic [21:1] a);
		return {a[20], a[7], a[8], a[21], a[6:3], a[20], a[7], a[2], a[1]};
	endfunction

	task automatic checkAddr(input string what, input logic [`ROW_BITS-1:0] got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t: %s RA %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkStrobe(input string what, input logic got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic checkState(input string what, input logic gotReady, input region_e gotReg,
		input logic expReady, input region_e expReg);
		checks++;
		if (gotReady !== expReady || gotReg !== expReg) begin
			errors++;
			$display("ERROR %0t: %s ramReady %b region %s, expected %b %s", $time, what,
				gotReady, gotReg.name(), expReady, expReg.name());
		end
	endtask

	task automatic checkCount(input string what, input int got, exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("ERROR %0t: %s %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic nextCycle;
		@(posedge CLK);
		#1;   // Drive point
	endtask

	task automatic checkColumn(input entry_t e);
		checkAddr("column", RA, colOf(e.addr));
		checkStrobe("nCAS", nCAS, 1'b0);
		checkStrobe("nOE", nOE, e.write);
		checkStrobe("nLWE", nLWE, !(e.write && e.lanes[0]));
		checkStrobe("nUWE", nUWE, !(e.write && e.lanes[1]));
	endtask

	task automatic checkRom(input entry_t e);
		checkStrobe("nROMCS", nROMCS, 1'b0);
		checkStrobe("nROMWE", nROMWE, !e.write);
		checkStrobe("RA8 as A18", RA[8], e.addr[18]);
		checkStrobe("RA11 as A19", RA[11], e.addr[19]);
		if (ramReady === 1'b1)
			checkStrobe("nRAS in ROM", nRAS, 1'b1);   // Refresh may strobe RAS meanwhile
	endtask

	task automatic ramCycle(input entry_t e);
		checkAddr("row", RA, rowOf(e.addr));
		checkStrobe("nLWE in row phase", nLWE, 1'b1);
		checkStrobe("nUWE in row phase", nUWE, 1'b1);
		if (ramReady === 1'b1)
			checkStrobe("nRAS from /AS", nRAS, 1'b0);   // A running refresh keeps it high
		// A refresh may run first, CAS for the access comes with ramReady high
		while (!(nCAS === 1'b0 && ramReady === 1'b1)) begin
			nextCycle;
			#2;
		end
		checkState("access", ramReady, uut.bus.region, 1'b1, e.expReg);
		checkColumn(e);
		repeat (e.dly) begin
			nextCycle;
			#2;
			checkColumn(e);
		end
		nextCycle;
		nDTACK = 1'b0;
		#2;
		while (nCAS === 1'b0) begin
			nextCycle;
			#2;
		end
	endtask

	task automatic romCycle(input entry_t e);
		checkRom(e);
		repeat (e.dly) begin
			nextCycle;
			#2;
			checkRom(e);
		end
		nextCycle;
		nDTACK = 1'b0;
		#2;
		checkRom(e);
		nextCycle;   // Lets the registered /DTACK reach nOE
		#2;
		checkRom(e);
	endtask

	task automatic runEntry(input entry_t e);
		nextCycle;
		A    = e.addr;
		nWE  = !e.write;
		nLDS = !e.lanes[0];
		nUDS = !e.lanes[1];
		nAS  = 1'b0;
		#2;
		if (e.expReg == regRom)
			romCycle(e);
		else
			ramCycle(e);
		nextCycle;
		nAS    = 1'b1;
		nDTACK = 1'b1;
		nWE    = 1'b1;
		nLDS   = 1'b1;
		nUDS   = 1'b1;
		#2;
		checkStrobe("nOE after cycle", nOE, 1'b1);
		checkStrobe("nLWE after cycle", nLWE, 1'b1);
		checkStrobe("nUWE after cycle", nUWE, 1'b1);
		checkStrobe("nROMCS after cycle", nROMCS, 1'b1);
		checkStrobe("nROMWE after cycle", nROMWE, 1'b1);
	endtask

	// Idle bus, so only an urgent request can start the CBR refresh
	task automatic refreshIdle;
		int waitCnt;
		int lowCnt;
		int rasCnt;
		waitCnt = 0;
		lowCnt  = 0;
		rasCnt  = 0;
		nextCycle;
		#2;
		while (ramReady !== 1'b0 && waitCnt < `REF_PERIOD + `REF_URGENT + 8) begin
			nextCycle;
			#2;
			waitCnt++;
		end
		if (ramReady !== 1'b0) begin
			errors++;
			$display("Refresh never started while the bus was idle");
		end else begin
			checkStrobe("nCAS at refresh start", nCAS, 1'b0);
			checkStrobe("nRAS at refresh start", nRAS, 1'b1);   // CAS before RAS
			while (ramReady === 1'b0) begin
				lowCnt++;
				if (nRAS === 1'b0) begin
					rasCnt++;
					checkStrobe("nCAS under refresh RAS", nCAS, 1'b0);
				end
				nextCycle;
				#2;
			end
			checkCount("ramReady low cycles", lowCnt, 6);
			checkCount("refresh nRAS low cycles", rasCnt, 2);
		end
	endtask

	initial begin
		void'($urandom(32'he3c4));
		rstN    = 1'b0;
		A       = '0;
		nWE     = 1'b1;
		nAS     = 1'b1;
		nLDS    = 1'b1;
		nUDS    = 1'b1;
		nDTACK  = 1'b1;
		repeat (4) @(posedge CLK);
		#1 rstN = 1'b1;
		#2;
		checkStrobe("nRAS after reset", nRAS, 1'b1);
		checkStrobe("nCAS after reset", nCAS, 1'b1);
		checkStrobe("nLWE after reset", nLWE, 1'b1);
		checkStrobe("nUWE after reset", nUWE, 1'b1);
		checkStrobe("nOE after reset", nOE, 1'b1);
		checkStrobe("nROMCS after reset", nROMCS, 1'b1);
		checkStrobe("nROMWE after reset", nROMWE, 1'b1);
		checkState("reset", ramReady, uut.bus.region, 1'b1, regRamLow);

		for (int i = 0; i < NumEntries; i++) begin
			gap = $urandom_range(6, 1);   // Shifts refresh against the accesses
			repeat (gap) nextCycle;
			runEntry(stim[i]);
		end

		refreshIdle;
		runEntry(stim[0]);   // Access right after refresh

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: tb.f
+incdir+hw
hw/memPkg.sv
hw/cpuBusIf.sv
hw/busDecode.sv
hw/refreshTimer.sv
hw/dramCtrl.sv
hw/dramPins.sv
hw/memTop.sv
sim/memTb.sv

// File: Bender.yml
package:
  name: memctl

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/memPkg.sv
      - hw/cpuBusIf.sv
      - hw/busDecode.sv
      - hw/refreshTimer.sv
      - hw/dramCtrl.sv
      - hw/dramPins.sv
      - hw/memTop.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/memTb.sv
